//--- pattern_lab_pkg.sv
package pattern_lab_pkg;

    localparam int NUM_LANES       = 4;
    localparam int PAT_W           = 3;
    localparam int COUNT_W         = 8;
    localparam int HIST_W          = 12;
    localparam int SW_W            = 8;
    localparam int NUM_DIGITS      = 8;

    localparam int STROBE_PERIOD   = 16;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int SCAN_PERIOD     = 4;

    localparam int DB_W            = SW_W + 1;       // serial key plus the switches.
    localparam int NUMBER_W        = NUM_LANES * COUNT_W;
    localparam int STROBE_CNT_W    = $clog2(STROBE_PERIOD);
    localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES);
    localparam int SCAN_CNT_W      = $clog2(SCAN_PERIOD);
    localparam int DIGIT_IDX_W     = $clog2(NUM_DIGITS);

    // Lane n watches for LANE_PATTERN[n]. The MSB is the oldest bit.
    localparam logic [NUM_LANES-1:0][PAT_W-1:0] LANE_PATTERN = {
        3'b111,
        3'b011,
        3'b110,
        3'b101
    };

    // The encoding is the length of the matched prefix.
    typedef enum logic [1:0] {
        DET_IDLE = 2'd0,
        DET_ONE  = 2'd1,
        DET_TWO  = 2'd2,
        DET_FULL = 2'd3
    } det_state_e;

    typedef enum logic {
        SCAN_BLANK = 1'b0,
        SCAN_DRIVE = 1'b1
    } scan_state_e;

endpackage

//--- stream_source.sv
`timescale 1ns/1ps

module stream_source (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic                               i_serial,
    input  logic [pattern_lab_pkg::SW_W-1:0]   i_sw,
    output logic                               o_bit,
    output logic                               o_strobe,
    output logic [pattern_lab_pkg::SW_W-1:0]   o_sw_db,
    output logic [pattern_lab_pkg::HIST_W-1:0] o_history
);

    import pattern_lab_pkg::*;

    logic [DB_W-1:0]                raw_in;
    logic [DB_W-1:0]                sync_q1;
    logic [DB_W-1:0]                sync_q2;
    logic [DB_W-1:0]                db_q;
    logic [DB_W-1:0][DEB_CNT_W-1:0] stab_cnt;
    logic [STROBE_CNT_W-1:0]        div_cnt;
    logic                           strobe_q;
    logic [HIST_W-1:0]              hist_q;

    assign raw_in = {i_sw, i_serial}; // the serial key sits in bit 0.

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= raw_in;
            sync_q2 <= sync_q1;
        end
    end

    // A bit follows its synchronized input only after it has differed for
    // DEBOUNCE_CYCLES clocks in a row.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            db_q     <= '0;
            stab_cnt <= '0;
        end else begin
            for (int i = 0; i < DB_W; i++) begin
                if (sync_q2[i] == db_q[i]) begin
                    stab_cnt[i] <= '0; // a glitch shorter than the window is dropped.
                end else if (stab_cnt[i] == DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    db_q[i]     <= sync_q2[i];
                    stab_cnt[i] <= '0;
                end else begin
                    stab_cnt[i] <= stab_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt  <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= (div_cnt == STROBE_CNT_W'(STROBE_PERIOD - 1));
            div_cnt  <= div_cnt + 1'b1; // wraps at STROBE_PERIOD.
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hist_q <= '0;
        end else if (strobe_q) begin
            hist_q <= {hist_q[HIST_W-2:0], db_q[0]}; // newest bit enters at bit 0.
        end
    end

    assign o_bit     = db_q[0];
    assign o_sw_db   = db_q[DB_W-1:1];
    assign o_strobe  = strobe_q;
    assign o_history = hist_q;

endmodule

//--- seq_detector.sv
`timescale 1ns/1ps

module seq_detector #(
    parameter logic [pattern_lab_pkg::PAT_W-1:0] PATTERN = pattern_lab_pkg::LANE_PATTERN[0]
) (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_strobe,
    input  logic                                i_bit,
    output logic [pattern_lab_pkg::COUNT_W-1:0] o_count
);

    import pattern_lab_pkg::*;

    det_state_e         state_q;
    det_state_e         state_d;
    logic [COUNT_W-1:0] count_q;

    // Finds the longest prefix of PATTERN that ends at the new bit.
    // The bits seen so far are exactly the prefix the current state names.
    function automatic det_state_e next_state(input det_state_e cur, input logic b);
        logic [PAT_W:0] pat_ext;
        logic [PAT_W:0] seen;
        logic [PAT_W:0] mask;
        int             len;
        det_state_e     nxt;
        pat_ext = {1'b0, PATTERN};
        len     = int'(cur) + 1;
        seen    = ((pat_ext >> (PAT_W - int'(cur))) << 1) | {{PAT_W{1'b0}}, b};
        nxt     = DET_IDLE;
        for (int k = 1; k <= PAT_W; k++) begin
            mask = ({{PAT_W{1'b0}}, 1'b1} << k) - 1'b1;
            if (k <= len && (seen & mask) == (pat_ext >> (PAT_W - k))) begin
                nxt = det_state_e'(k); // larger k wins, giving the longest overlap.
            end
        end
        return nxt;
    endfunction

    always_comb begin
        state_d = state_q;
        if (i_strobe) begin
            state_d = next_state(state_q, i_bit);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= DET_IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            if (i_strobe && state_d == DET_FULL) begin
                count_q <= count_q + 1'b1; // wraps at 256.
            end
        end
    end

    assign o_count = count_q;

endmodule

//--- count_display.sv
`timescale 1ns/1ps

module count_display (
    input  logic                                                          clk,
    input  logic                                                          i_rst_n,
    input  logic [pattern_lab_pkg::NUM_LANES-1:0][pattern_lab_pkg::COUNT_W-1:0] i_counts,
    input  logic [pattern_lab_pkg::SW_W-1:0]                              i_dots,
    output logic [pattern_lab_pkg::NUMBER_W-1:0]                          o_number,
    output logic [7:0]                                                    o_abcdefgh,
    output logic [pattern_lab_pkg::NUM_DIGITS-1:0]                        o_digit
);

    import pattern_lab_pkg::*;

    scan_state_e             scan_state_q;
    logic [SCAN_CNT_W-1:0]   scan_cnt_q;
    logic [DIGIT_IDX_W-1:0]  digit_idx_q;
    logic [3:0]              nibble;
    logic [6:0]              seg_on;
    logic                    dot_on;

    always_comb begin
        for (int n = 0; n < NUM_LANES; n++) begin
            o_number[(NUM_LANES - 1 - n) * COUNT_W +: COUNT_W] = i_counts[n]; // lane 0 on top.
        end
    end

    // Each digit gets SCAN_PERIOD cycles and the first of them is blank.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_state_q <= SCAN_BLANK;
            scan_cnt_q   <= '0;
            digit_idx_q  <= '0;
        end else if (scan_cnt_q == SCAN_CNT_W'(SCAN_PERIOD - 1)) begin
            scan_state_q <= SCAN_BLANK;
            scan_cnt_q   <= '0;
            digit_idx_q  <= digit_idx_q + 1'b1; // wraps after the last digit.
        end else begin
            scan_state_q <= SCAN_DRIVE;
            scan_cnt_q   <= scan_cnt_q + 1'b1;
        end
    end

    assign nibble = o_number[digit_idx_q * 4 +: 4];
    assign dot_on = i_dots[digit_idx_q];

    always_comb begin
        case (nibble) // segments a to g, active high here.
            4'h0:    seg_on = 7'b1111110;
            4'h1:    seg_on = 7'b0110000;
            4'h2:    seg_on = 7'b1101101;
            4'h3:    seg_on = 7'b1111001;
            4'h4:    seg_on = 7'b0110011;
            4'h5:    seg_on = 7'b1011011;
            4'h6:    seg_on = 7'b1011111;
            4'h7:    seg_on = 7'b1110000;
            4'h8:    seg_on = 7'b1111111;
            4'h9:    seg_on = 7'b1111011;
            4'ha:    seg_on = 7'b1110111;
            4'hb:    seg_on = 7'b0011111;
            4'hc:    seg_on = 7'b1001110;
            4'hd:    seg_on = 7'b0111101;
            4'he:    seg_on = 7'b1001111;
            default: seg_on = 7'b1000111;
        endcase
    end

    always_comb begin
        o_digit    = '1;
        o_abcdefgh = '1; // all segments dark while blanking.
        if (scan_state_q == SCAN_DRIVE) begin
            o_digit[digit_idx_q] = 1'b0;
            o_abcdefgh           = ~{seg_on, dot_on};
        end
    end

endmodule

//--- pattern_lab_top.sv
`timescale 1ns/1ps

module pattern_lab_top (
    input  logic                                   clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_serial,
    input  logic [pattern_lab_pkg::SW_W-1:0]       i_sw,
    output logic [pattern_lab_pkg::HIST_W-1:0]     o_led,
    output logic [7:0]                             o_abcdefgh,
    output logic [pattern_lab_pkg::NUM_DIGITS-1:0] o_digit,
    output logic [pattern_lab_pkg::NUMBER_W-1:0]   o_counts
);

    import pattern_lab_pkg::*;

    logic                               sample_bit;
    logic                               sample_strobe;
    logic [SW_W-1:0]                    sw_db;
    logic [NUM_LANES-1:0][COUNT_W-1:0]  lane_counts;

    stream_source i_stream_source (
        .clk       ( clk           ),
        .i_rst_n   ( i_rst_n       ),
        .i_serial  ( i_serial      ),
        .i_sw      ( i_sw          ),
        .o_bit     ( sample_bit    ),
        .o_strobe  ( sample_strobe ),
        .o_sw_db   ( sw_db         ),
        .o_history ( o_led         )
    );

    // All lanes sample the same bit on the same strobe.
    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        seq_detector #(.PATTERN (LANE_PATTERN[n])) i_seq_detector (
            .clk      ( clk            ),
            .i_rst_n  ( i_rst_n        ),
            .i_strobe ( sample_strobe  ),
            .i_bit    ( sample_bit     ),
            .o_count  ( lane_counts[n] )
        );
    end

    count_display i_count_display (
        .clk        ( clk         ),
        .i_rst_n    ( i_rst_n     ),
        .i_counts   ( lane_counts ),
        .i_dots     ( sw_db       ),
        .o_number   ( o_counts    ),
        .o_abcdefgh ( o_abcdefgh  ),
        .o_digit    ( o_digit     )
    );

endmodule

//--- pattern_lab_sva.sv
`timescale 1ns/1ps

module pattern_lab_sva (
    input logic                                   clk,
    input logic                                   i_rst_n,
    input logic                                   i_strobe,
    input logic [pattern_lab_pkg::HIST_W-1:0]     i_history,
    input logic [pattern_lab_pkg::NUM_DIGITS-1:0] i_digit,
    input logic [pattern_lab_pkg::NUMBER_W-1:0]   i_counts
);

    // the history moves only on the edge that sees the strobe.
    a_shift_on_strobe: assert property (
        @(posedge clk) disable iff (!i_rst_n) !i_strobe |=> $stable(i_history)
    ) else $error("history changed without a sample strobe");

    // at most one select is low, and a select never moves to another digit
    // without a blank cycle in between.
    a_digit_onehot: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        $onehot0(~i_digit) && (i_digit == '1 || $past(i_digit) == '1 || $stable(i_digit))
    ) else $error("digit selects overlap or switch digits without a blank cycle");

    a_reset_values: assert property (
        @(posedge clk) !i_rst_n |-> (i_history == '0 && i_counts == '0 && i_digit == '1)
    ) else $error("history, counts or digit selects not at reset value");

endmodule

bind pattern_lab_top pattern_lab_sva sva_checks (
    .clk       ( clk           ),
    .i_rst_n   ( i_rst_n       ),
    .i_strobe  ( sample_strobe ),
    .i_history ( o_led         ),
    .i_digit   ( o_digit       ),
    .i_counts  ( o_counts      )
);

//--- pattern_lab_tb.sv
`timescale 1ns/1ps

module pattern_lab_tb;

    import pattern_lab_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int N_HIST      = 40;
    localparam int N_DETECT    = 200;
    localparam int N_GLITCH    = 12;
    localparam int MAX_BITS    = N_HIST + N_DETECT + N_GLITCH;
    localparam int SCAN_CYCLES = 2 * NUM_DIGITS * SCAN_PERIOD;
    // One strobe period per bit, plus room for reset and the display scan.
    localparam longint TIMEOUT_NS = longint'(MAX_BITS + 30) * STROBE_PERIOD * CLK_PERIOD;
    // The oldest bit is sent first, so the stream starts with 10101 and then 1111.
    localparam logic [8:0] DIRECTED = 9'b101011111;

    localparam logic [PAT_W-1:0] REF_PATTERN [NUM_LANES] = '{3'b101, 3'b110, 3'b011, 3'b111};

    logic                  clk;
    logic                  i_rst_n;
    logic                  i_serial;
    logic [SW_W-1:0]       i_sw;
    logic [HIST_W-1:0]     o_led;
    logic [7:0]            o_abcdefgh;
    logic [NUM_DIGITS-1:0] o_digit;
    logic [NUMBER_W-1:0]   o_counts;

    integer                seed;
    logic                  sent_bits [MAX_BITS];
    int                    num_sent;
    int                    num_checks;
    int                    num_errors;
    int                    test_errors;
    logic                  display_on;
    logic [NUM_DIGITS-1:0] digits_seen;

    pattern_lab_top DUT (
        .clk        ( clk        ),
        .i_rst_n    ( i_rst_n    ),
        .i_serial   ( i_serial   ),
        .i_sw       ( i_sw       ),
        .o_led      ( o_led      ),
        .o_abcdefgh ( o_abcdefgh ),
        .o_digit    ( o_digit    ),
        .o_counts   ( o_counts   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Replays the sampled bits, returning the packed counts above the history.
    function automatic logic [NUMBER_W+HIST_W-1:0] reference_result(input int n);
        logic [HIST_W-1:0]   hist;
        logic [PAT_W-1:0]    window;
        logic [COUNT_W-1:0]  cnt [NUM_LANES];
        logic [NUMBER_W-1:0] packed_cnt;
        hist       = '0;
        window     = '0;
        packed_cnt = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            cnt[l] = '0;
        end
        for (int i = 0; i < n; i++) begin
            hist   = {hist[HIST_W-2:0], sent_bits[i]};
            window = {window[PAT_W-2:0], sent_bits[i]};
            for (int l = 0; l < NUM_LANES; l++) begin
                if (i >= PAT_W - 1 && window == REF_PATTERN[l]) begin
                    cnt[l] = cnt[l] + 1'b1; // wraps at 256.
                end
            end
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            packed_cnt[NUMBER_W - COUNT_W * (l + 1) +: COUNT_W] = cnt[l];
        end
        return {packed_cnt, hist};
    endfunction

    function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
        logic [6:0] abcdefg;
        case (nibble) // a is the MSB.
            4'h0: abcdefg = 7'h7e;
            4'h1: abcdefg = 7'h30;
            4'h2: abcdefg = 7'h6d;
            4'h3: abcdefg = 7'h79;
            4'h4: abcdefg = 7'h33;
            4'h5: abcdefg = 7'h5b;
            4'h6: abcdefg = 7'h5f;
            4'h7: abcdefg = 7'h70;
            4'h8: abcdefg = 7'h7f;
            4'h9: abcdefg = 7'h7b;
            4'ha: abcdefg = 7'h77;
            4'hb: abcdefg = 7'h1f;
            4'hc: abcdefg = 7'h4e;
            4'hd: abcdefg = 7'h3d;
            4'he: abcdefg = 7'h4f;
            default: abcdefg = 7'h47;
        endcase
        return abcdefg;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        num_checks++;
        if (expected !== actual) begin
            num_errors++;
            test_errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAIL", test_errors);
        test_errors = 0;
    endtask

    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Returns 1 ns after the clock edge that shifts the history.
    task automatic wait_shift();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < 2 * STROBE_PERIOD && !seen; i++) begin
            @(negedge clk);
            seen = DUT.sample_strobe;
        end
        if (!seen) begin
            num_errors++;
            test_errors++;
            $display("ERROR: no sample strobe within %0d cycles", 2 * STROBE_PERIOD);
        end
        @(posedge clk);
        #1;
    endtask

    // The glitch is shorter than the debounce window and ends just before the
    // strobe, so an input without debounce would be sampled inverted.
    task automatic send_bit(input logic b, input bit glitch);
        i_serial = b;
        if (glitch) begin
            step_cycles(11);
            i_serial = ~b;
            step_cycles(2);
            i_serial = b;
        end
        wait_shift();
        sent_bits[num_sent] = b;
        num_sent++;
    endtask

    always @(negedge clk) begin
        logic [7:0] exp_seg;
        int         d;
        if (display_on && $onehot(~o_digit)) begin
            d = 0;
            for (int k = 0; k < NUM_DIGITS; k++) begin
                if (!o_digit[k]) begin
                    d = k;
                end
            end
            exp_seg = ~{seg_pattern(o_counts[d*4 +: 4]), i_sw[d]}; // active low, dot last.
            check_value($sformatf("digit %0d segments", d), exp_seg, o_abcdefgh);
            digits_seen[d] = 1'b1;
        end
    end

    initial begin
        logic [NUMBER_W+HIST_W-1:0] expected;
        int                         rnd;
        seed        = 38;
        i_rst_n     = 1'b0;
        i_serial    = 1'b0;
        i_sw        = '0;
        display_on  = 1'b0;
        digits_seen = '0;
        num_sent    = 0;
        num_checks  = 0;
        num_errors  = 0;
        test_errors = 0;

        step_cycles(2);
        i_rst_n = 1'b1;
        @(negedge clk);
        check_value("reset o_led", '0, o_led);
        check_value("reset o_counts", '0, o_counts);
        check_value("reset o_digit", {NUM_DIGITS{1'b1}}, o_digit);
        finish_test("reset");
        step_cycles(1);

        for (int i = 0; i < N_HIST; i++) begin
            rnd = $random(seed);
            send_bit(rnd[0], 1'b0);
        end
        expected = reference_result(num_sent);
        check_value("history", expected[HIST_W-1:0], o_led);
        finish_test("history");

        for (int i = 0; i < N_DETECT; i++) begin
            rnd = $random(seed);
            send_bit((i < 9) ? DIRECTED[8-i] : rnd[0], 1'b0);
        end
        expected = reference_result(num_sent);
        for (int l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("lane %0d count", l),
                        expected[HIST_W + NUMBER_W - COUNT_W * (l + 1) +: COUNT_W],
                        o_counts[NUMBER_W - COUNT_W * (l + 1) +: COUNT_W]);
        end
        finish_test("detection");

        for (int i = 0; i < N_GLITCH; i++) begin
            rnd = $random(seed);
            send_bit(rnd[0], 1'b1);
        end
        expected = reference_result(num_sent);
        check_value("debounced history", expected[HIST_W-1:0], o_led);
        check_value("debounced counts", expected[NUMBER_W+HIST_W-1:HIST_W], o_counts);
        finish_test("debounce");

        i_sw = $random(seed);
        step_cycles(2 * DEBOUNCE_CYCLES + 4); // switches must pass the debounce first.
        display_on = 1'b1;
        step_cycles(SCAN_CYCLES);
        display_on = 1'b0;
        if (digits_seen != {NUM_DIGITS{1'b1}}) begin
            num_errors++;
            test_errors++;
            $display("ERROR: not every digit was selected during the scan, seen %b", digits_seen);
        end
        finish_test("display");

        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

endmodule

//--- pattern_lab.f
pattern_lab_pkg.sv
stream_source.sv
seq_detector.sv
count_display.sv
pattern_lab_top.sv
pattern_lab_sva.sv
pattern_lab_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds with Verilator, runs the simulation and looks for the pass line in sim.log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pattern_lab_tb \
    -f pattern_lab.f -o pattern_lab_sim > build.log 2>&1 \
    && ./obj_dir/pattern_lab_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -qx "test passed" sim.log \
    && echo "simulation result: ok" \
    || { echo "simulation result: failure, see sim.log"; exit 1; }
